// ==== sources.f ====
+incdir+verif
hw/fetch_pkg.sv
hw/core_bus_if.sv
hw/l0_fifo.sv
hw/fetch.sv
hw/fetch_top.sv
verif/tb_fetch_top.sv

// ==== Makefile ====
# Verilator build and run of the fetch stage testbench

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f sources.f --top-module tb_fetch_top \
		-Mdir obj_dir -o Vtb_fetch_top
	./obj_dir/Vtb_fetch_top

clean:
	rm -rf obj_dir

// ==== verif/tb_fetch_checks.svh ====
// Reference model, random source, compare tasks and bounded wait tasks; included by the fetch testbench

// Expected instruction word for a fetch address
function automatic fetch_pkg::instr_raw_t ref_instr(input fetch_pkg::pc_t addr);
  logic [31:0] x;
  x = addr ^ 32'hA5C3_5A3C;
  return {x[24:0], x[31:25]};
endfunction

// Addresses that the memory model answers with an error
function automatic logic in_fault_window(input fetch_pkg::pc_t addr);
  return (addr >= 32'h0000_F000) && (addr <= 32'h0000_F0FF);
endfunction

function automatic logic [31:0] xorshift32(input logic [31:0] s);
  logic [31:0] x;
  x = s;
  x = x ^ (x << 13);
  x = x ^ (x >> 17);
  x = x ^ (x << 5);
  return x;
endfunction

function automatic logic [31:0] next_rand();
  rng_state = xorshift32(rng_state);
  return rng_state;
endfunction

task automatic check_instr(input string name, input fetch_pkg::instr_raw_t got,
                           input fetch_pkg::instr_raw_t exp);
  if (got !== exp) begin
    $display("[FAIL] %s got 0x%08h expected 0x%08h", name, got, exp);
    abort_run("instruction mismatch");
  end
endtask

// Offending address only matters while the trap is active
task automatic check_trap(input string name, input fetch_pkg::trap_info_t got,
                          input fetch_pkg::trap_info_t exp);
  if ((got.active !== exp.active) || (exp.active && (got.mtval !== exp.mtval))) begin
    $display("[FAIL] %s got 0x%09h expected 0x%09h", name, got, exp);
    abort_run("trap report mismatch");
  end
endtask

task automatic check_fault(input string name, input logic got, input logic exp);
  if (got !== exp) begin
    $display("[FAIL] %s got 0x%01h expected 0x%01h", name, got, exp);
    abort_run("access fault mismatch");
  end
endtask

task automatic check_size(input string name, input fetch_pkg::cb_size_e got,
                          input fetch_pkg::cb_size_e exp);
  if (got !== exp) begin
    $display("[FAIL] %s got 0x%01h expected 0x%01h", name, got, exp);
    abort_run("transfer size mismatch");
  end
endtask

task automatic next_cycle();
  @(posedge clk);
  #1;
endtask

task automatic wait_consumed(input int target, input int limit);
  int n;
  n = 0;
  while (consumed < target) begin
    if (n >= limit) abort_run("timed out waiting for instructions at the decode side");
    next_cycle();
    n++;
  end
endtask

task automatic wait_outstanding(input int target, input int limit);
  int n;
  n = 0;
  while (mq.size() < target) begin
    if (n >= limit) abort_run("timed out waiting for outstanding bus requests");
    next_cycle();
    n++;
  end
endtask

task automatic wait_faults(input int target, input int limit);
  int n;
  n = 0;
  while (fault_cnt < target) begin
    if (n >= limit) abort_run("timed out waiting for access fault pulses");
    next_cycle();
    n++;
  end
endtask

// ==== verif/tb_fetch_top.sv ====
// Testbench for the fetch stage top level with a core bus memory model and a decode-side checker
`timescale 1ns/100ps

module tb_fetch_top;

  logic                  clk;
  logic                  arst_n_i;
  logic                  fetch_start_i;
  fetch_pkg::pc_t        fetch_start_addr_i;
  logic                  fetch_req_i;
  fetch_pkg::pc_t        fetch_addr_i;
  logic                  rd_addr_valid_o;
  fetch_pkg::pc_t        rd_addr_o;
  fetch_pkg::cb_size_e   rd_size_o;
  logic                  rd_addr_ready_i;
  logic                  rd_valid_i;
  fetch_pkg::instr_raw_t rd_data_i;
  fetch_pkg::cb_resp_e   rd_resp_i;
  logic                  rd_ready_o;
  logic                  fetch_valid_o;
  fetch_pkg::instr_raw_t fetch_instr_o;
  logic                  fetch_ready_i;
  logic                  instr_access_fault_o;
  fetch_pkg::trap_info_t trap_info_o;

  logic [31:0]    rng_state = 32'h7061;
  fetch_pkg::pc_t mq[$];
  int             dq[$];
  logic           stall = 1'b0;
  logic           bp_en = 1'b0;
  logic           fault_mode = 1'b0;
  fetch_pkg::pc_t next_base = '0;
  int             load_cnt = 0;
  int             consumed = 0;
  int             fault_cnt = 0;

  task automatic abort_run(input string why);
    $display("SOME TESTS FAILED");
    $fatal(1, "%s", why);
  endtask

  `include "tb_fetch_checks.svh"

  fetch_top uut (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Memory model, replies in order after 1 to 4 cycles
  initial begin
    logic [31:0] r;
    rd_addr_ready_i = 1'b0;
    rd_valid_i      = 1'b0;
    rd_data_i       = '0;
    rd_resp_i       = fetch_pkg::CB_OKAY;
    forever begin
      @(posedge clk);
      if (rd_valid_i && rd_ready_o) begin
        void'(mq.pop_front());
        void'(dq.pop_front());
      end
      if (rd_addr_valid_o && rd_addr_ready_i) begin
        // Fetch only ever reads whole words
        check_size("rd_size_o", rd_size_o, fetch_pkg::CB_WORD);
        r = next_rand();
        mq.push_back(rd_addr_o);
        dq.push_back(1 + int'(r % 32'd4));
      end
      if (mq.size() > 4) abort_run("more than four bus requests outstanding");
      #1;
      r = next_rand();
      rd_addr_ready_i = (r[1:0] != 2'b00);
      if (mq.size() > 0 && dq[0] > 0) dq[0] = dq[0] - 1;
      if (mq.size() > 0 && dq[0] == 0 && (!stall || rd_valid_i)) begin
        rd_valid_i = 1'b1;
        rd_data_i  = in_fault_window(mq[0]) ? '0 : ref_instr(mq[0]);
        rd_resp_i  = in_fault_window(mq[0]) ? fetch_pkg::CB_ERROR : fetch_pkg::CB_OKAY;
      end else begin
        rd_valid_i = 1'b0;
      end
    end
  end

  // Decode back-pressure
  initial begin
    logic [31:0] r;
    fetch_ready_i = 1'b1;
    forever begin
      @(posedge clk);
      #1;
      r = next_rand();
      fetch_ready_i = bp_en ? r[2] : 1'b1;
    end
  end

  // Decode-side checker
  initial begin
    fetch_pkg::pc_t        exp_pc;
    fetch_pkg::instr_raw_t held_instr;
    fetch_pkg::trap_info_t exp_trap;
    logic start_prev;
    logic req_prev;
    logic trig_seen;
    logic hold_pend;
    int   load_seen;
    exp_pc     = '0;
    held_instr = '0;
    start_prev = 1'b0;
    req_prev   = 1'b0;
    hold_pend  = 1'b0;
    load_seen  = 0;
    forever begin
      @(posedge clk);
      if (arst_n_i) begin
        if (load_cnt != load_seen) begin
          exp_pc    = next_base;
          load_seen = load_cnt;
        end
        trig_seen  = (fetch_start_i && !start_prev) || (fetch_req_i && !req_prev);
        start_prev = fetch_start_i;
        req_prev   = fetch_req_i;
        exp_trap.active = fetch_req_i && (fetch_addr_i[1:0] != 2'b00);
        exp_trap.mtval  = fetch_addr_i;
        check_trap("trap_info_o", trap_info_o, exp_trap);
        if (fault_mode) begin
          if (instr_access_fault_o) fault_cnt++;
        end else begin
          check_fault("instr_access_fault_o", instr_access_fault_o, 1'b0);
        end
        if (trig_seen) begin
          if (fetch_valid_o) abort_run("decode valid high in a trigger cycle");
        end else if (hold_pend) begin
          if (!fetch_valid_o) abort_run("decode valid dropped while ready was low");
          check_instr("fetch_instr_o (held)", fetch_instr_o, held_instr);
        end
        if (fetch_valid_o && fetch_ready_i && !trig_seen) begin
          if (fault_mode) abort_run("instruction delivered from the fault window");
          check_instr("fetch_instr_o", fetch_instr_o, ref_instr(exp_pc));
          exp_pc = exp_pc + 32'd4;
          consumed++;
        end
        hold_pend  = fetch_valid_o && !fetch_ready_i && !trig_seen;
        held_instr = fetch_instr_o;
      end
    end
  end

  initial begin
    repeat (200000) @(posedge clk);
    abort_run("simulation watchdog expired");
  end

  task automatic drive_start(input fetch_pkg::pc_t addr);
    fetch_start_addr_i = addr;
    fetch_start_i      = 1'b1;
    next_base          = addr;
    load_cnt++;
    next_cycle();
    fetch_start_i = 1'b0;
  endtask

  task automatic drive_redirect(input fetch_pkg::pc_t addr, input int hold);
    fetch_addr_i = addr;
    fetch_req_i  = 1'b1;
    next_base    = {addr[31:2], 2'b00};
    load_cnt++;
    repeat (hold) next_cycle();
    fetch_req_i = 1'b0;
  endtask

  initial begin
    arst_n_i           = 1'b0;
    fetch_start_i      = 1'b0;
    fetch_start_addr_i = '0;
    fetch_req_i        = 1'b0;
    fetch_addr_i       = '0;
    repeat (16) @(posedge clk);
    #1;
    arst_n_i = 1'b1;
    next_cycle();

    // Start and stream, then the same with decode back-pressure
    drive_start(32'h0000_1000);
    wait_consumed(40, 2000);
    bp_en = 1'b1;
    wait_consumed(consumed + 40, 4000);

    // Redirect with requests in flight
    wait_outstanding(1, 200);
    drive_redirect(32'h0000_2000, 1);
    wait_consumed(consumed + 20, 2000);

    // Misaligned redirect held for a few cycles
    drive_redirect(32'h0000_3002, 4);
    wait_consumed(consumed + 10, 2000);

    // Fault window, then recovery
    fault_mode = 1'b1;
    drive_start(32'h0000_F000);
    wait_faults(fault_cnt + 3, 2000);
    fault_mode = 1'b0;
    drive_redirect(32'h0000_5000, 1);
    wait_consumed(consumed + 20, 2000);

    // Outstanding limit with all replies stalled
    bp_en = 1'b0;
    stall = 1'b1;
    wait_outstanding(4, 500);
    repeat (20) next_cycle();
    stall = 1'b0;
    wait_consumed(consumed + 20, 2000);

    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

// ==== hw/fetch_top.sv ====
// Top level of the fetch stage, exposing the core bus read channel as plain ports
`timescale 1ns/100ps

module fetch_top (
  input  logic                  clk,
  input  logic                  arst_n_i,
  input  logic                  fetch_start_i,
  input  fetch_pkg::pc_t        fetch_start_addr_i,
  input  logic                  fetch_req_i,
  input  fetch_pkg::pc_t        fetch_addr_i,
  // Core bus, address phase
  output logic                  rd_addr_valid_o,
  output fetch_pkg::pc_t        rd_addr_o,
  output fetch_pkg::cb_size_e   rd_size_o,
  input  logic                  rd_addr_ready_i,
  // Core bus, data phase
  input  logic                  rd_valid_i,
  input  fetch_pkg::instr_raw_t rd_data_i,
  input  fetch_pkg::cb_resp_e   rd_resp_i,
  output logic                  rd_ready_o,
  // Decode stage
  output logic                  fetch_valid_o,
  output fetch_pkg::instr_raw_t fetch_instr_o,
  input  logic                  fetch_ready_i,
  // Faults and traps
  output logic                  instr_access_fault_o,
  output fetch_pkg::trap_info_t trap_info_o
);

  core_bus_if u_cb (.clk(clk));

  // Slave side of the bus mapped onto the top ports
  assign rd_addr_valid_o = u_cb.rd_addr_valid;
  assign rd_addr_o       = u_cb.rd_addr;
  assign rd_size_o       = u_cb.rd_size;
  assign rd_ready_o      = u_cb.rd_ready;
  assign u_cb.rd_addr_ready = rd_addr_ready_i;
  assign u_cb.rd_valid      = rd_valid_i;
  assign u_cb.rd_data       = rd_data_i;
  assign u_cb.rd_resp       = rd_resp_i;

  fetch u_fetch (
    .clk                  (clk),
    .arst_n_i             (arst_n_i),
    .cb                   (u_cb.master),
    .fetch_start_i        (fetch_start_i),
    .fetch_start_addr_i   (fetch_start_addr_i),
    .fetch_req_i          (fetch_req_i),
    .fetch_addr_i         (fetch_addr_i),
    .fetch_valid_o        (fetch_valid_o),
    .fetch_instr_o        (fetch_instr_o),
    .fetch_ready_i        (fetch_ready_i),
    .instr_access_fault_o (instr_access_fault_o),
    .trap_info_o          (trap_info_o)
  );

endmodule

// ==== hw/fetch.sv ====
// Instruction fetch stage: PC control, bus request issue, stale reply discard and fault reporting
`timescale 1ns/100ps

module fetch (
  input  logic                  clk,
  input  logic                  arst_n_i,
  core_bus_if.master            cb,
  input  logic                  fetch_start_i,
  input  fetch_pkg::pc_t        fetch_start_addr_i,
  input  logic                  fetch_req_i,
  input  fetch_pkg::pc_t        fetch_addr_i,
  output logic                  fetch_valid_o,
  output fetch_pkg::instr_raw_t fetch_instr_o,
  input  logic                  fetch_ready_i,
  output logic                  instr_access_fault_o,
  output fetch_pkg::trap_info_t trap_info_o
);

  fetch_pkg::fetch_state_e state_q, state_d;
  fetch_pkg::pc_t          pc_q, pc_d;
  fetch_pkg::ot_cnt_t      ot_q, ot_d;
  fetch_pkg::occ_t         buf_ocup;

  logic start_q;
  logic req_q;
  logic stale_q, stale_d;
  logic start_rise;
  logic req_rise;
  logic trig;
  logic buf_full;
  logic req_sent;
  logic resp_recv;
  logic resp_live;
  logic buf_write;
  logic buf_read;

  // Edge detection on start and redirect
  assign start_rise = fetch_start_i && !start_q;
  assign req_rise   = fetch_req_i && !req_q;
  assign trig       = start_rise || req_rise;

  assign buf_full = (buf_ocup == fetch_pkg::occ_t'(fetch_pkg::L0_SLOTS));

  // Address phase, PC is kept word aligned so it goes out as is
  assign cb.rd_addr_valid = (state_q != fetch_pkg::IDLE) && !trig && !stale_q && !buf_full &&
                            (ot_q < fetch_pkg::ot_cnt_t'(fetch_pkg::MAX_OT_TXN));
  assign cb.rd_addr       = pc_q;
  assign cb.rd_size       = fetch_pkg::CB_WORD;
  assign cb.rd_ready      = !buf_full;

  assign req_sent  = cb.rd_addr_valid && cb.rd_addr_ready;
  assign resp_recv = cb.rd_valid && cb.rd_ready;

  // Replies that belong to the current stream
  assign resp_live = resp_recv && !stale_q && !trig && (state_q == fetch_pkg::FETCH_RUN);

  assign buf_write            = resp_live && (cb.rd_resp == fetch_pkg::CB_OKAY);
  assign instr_access_fault_o = resp_live && (cb.rd_resp == fetch_pkg::CB_ERROR);

  // Decode side
  assign fetch_valid_o = (buf_ocup != '0) && !trig;
  assign buf_read      = fetch_valid_o && fetch_ready_i;

  // Misaligned redirect target
  always_comb begin
    trap_info_o        = '0;
    trap_info_o.active = fetch_req_i && (fetch_addr_i[1:0] != 2'b00);
    if (trap_info_o.active) begin
      trap_info_o.mtval = fetch_addr_i;
    end
  end

  always_comb begin
    pc_d = pc_q;
    if (trig) begin
      // Start has priority when both rise together
      pc_d = start_rise ? {fetch_start_addr_i[31:2], 2'b00} : {fetch_addr_i[31:2], 2'b00};
    end else if (req_sent) begin
      pc_d = pc_q + 32'd4;
    end
  end

  // Every reply decrements, stale ones included
  assign ot_d = ot_q + fetch_pkg::ot_cnt_t'(req_sent) - fetch_pkg::ot_cnt_t'(resp_recv);

  // Discard mode holds until everything issued before the trigger is back
  always_comb begin
    if (trig) begin
      stale_d = (ot_d != '0);
    end else if (state_q == fetch_pkg::IDLE) begin
      stale_d = stale_q;
    end else begin
      stale_d = stale_q && (ot_d != '0);
    end
  end

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      fetch_pkg::IDLE: begin
        if (trig) begin
          state_d = fetch_pkg::FETCH_CLEAR;
        end
      end
      fetch_pkg::FETCH_CLEAR: begin
        state_d = trig ? fetch_pkg::FETCH_CLEAR : fetch_pkg::FETCH_RUN;
      end
      fetch_pkg::FETCH_RUN: begin
        if (trig) begin
          state_d = fetch_pkg::FETCH_CLEAR;
        end
      end
      default: state_d = fetch_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= fetch_pkg::IDLE;
      pc_q    <= '0;
      ot_q    <= '0;
      stale_q <= 1'b1;
      start_q <= 1'b0;
      req_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      pc_q    <= pc_d;
      ot_q    <= ot_d;
      stale_q <= stale_d;
      start_q <= fetch_start_i;
      req_q   <= fetch_req_i;
    end
  end

  l0_fifo u_l0_fifo (
    .clk      (clk),
    .arst_n_i (arst_n_i),
    .clear_i  (trig),
    .write_i  (buf_write),
    .read_i   (buf_read),
    .data_i   (cb.rd_data),
    .data_o   (fetch_instr_o),
    .ocup_o   (buf_ocup)
  );

  // The slave may hold ready high, so the limit depends on the issue gating over time
  a_ot_limit: assert property (@(posedge clk) disable iff (!arst_n_i)
    ot_q <= fetch_pkg::ot_cnt_t'(fetch_pkg::MAX_OT_TXN))
    else $error("Outstanding read count above limit");

  // Alignment relies on every PC load path dropping the low bits
  a_addr_aligned: assert property (@(posedge clk) disable iff (!arst_n_i)
    cb.rd_addr_valid |-> (cb.rd_addr[1:0] == 2'b00))
    else $error("Unaligned fetch address on core bus");

endmodule

// ==== hw/l0_fifo.sv ====
// Small circular instruction buffer between the core bus replies and the decode stage
`timescale 1ns/100ps

module l0_fifo (
  input  logic                  clk,
  input  logic                  arst_n_i,
  input  logic                  clear_i,
  input  logic                  write_i,
  input  logic                  read_i,
  input  fetch_pkg::instr_raw_t data_i,
  output fetch_pkg::instr_raw_t data_o,
  output fetch_pkg::occ_t       ocup_o
);

  fetch_pkg::instr_raw_t mem [fetch_pkg::L0_SLOTS];
  fetch_pkg::l0_ptr_t    wr_ptr_q;
  fetch_pkg::l0_ptr_t    rd_ptr_q;
  fetch_pkg::occ_t       ocup_q;
  logic                  full;
  logic                  empty;

  assign full   = (ocup_q == fetch_pkg::occ_t'(fetch_pkg::L0_SLOTS));
  assign empty  = (ocup_q == '0);
  assign data_o = mem[rd_ptr_q];
  assign ocup_o = ocup_q;

  // Pointer increment with wrap, also correct for depths that are not a power of two
  function automatic fetch_pkg::l0_ptr_t ptr_inc(input fetch_pkg::l0_ptr_t ptr);
    if (ptr == fetch_pkg::l0_ptr_t'(fetch_pkg::L0_SLOTS - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      ocup_q   <= '0;
    end else if (clear_i) begin
      // Clear wins over any write or read in the same cycle
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      ocup_q   <= '0;
    end else begin
      if (write_i) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (read_i) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      ocup_q <= ocup_q + fetch_pkg::occ_t'(write_i) - fetch_pkg::occ_t'(read_i);
    end
  end

  // Slot storage
  always_ff @(posedge clk) begin
    if (write_i && !clear_i) begin
      mem[wr_ptr_q] <= data_i;
    end
  end

  a_no_write_full: assert property (@(posedge clk) disable iff (!arst_n_i)
    !(write_i && !clear_i && full))
    else $error("L0 buffer written while full");

  a_no_read_empty: assert property (@(posedge clk) disable iff (!arst_n_i)
    !(read_i && empty))
    else $error("L0 buffer read while empty");

endmodule

// ==== hw/core_bus_if.sv ====
// Read channel of the core bus, used between the fetch stage and the top level ports
`timescale 1ns/100ps

interface core_bus_if (
  input logic clk
);

  // Address phase
  logic                rd_addr_valid;
  fetch_pkg::pc_t      rd_addr;
  fetch_pkg::cb_size_e rd_size;
  logic                rd_addr_ready;

  // Data phase, replies come back in request order
  logic                  rd_valid;
  fetch_pkg::instr_raw_t rd_data;
  fetch_pkg::cb_resp_e   rd_resp;
  logic                  rd_ready;

  modport master (
    input  clk,
    output rd_addr_valid, rd_addr, rd_size, rd_ready,
    input  rd_addr_ready, rd_valid, rd_data, rd_resp
  );

  modport slave (
    input  clk,
    input  rd_addr_valid, rd_addr, rd_size, rd_ready,
    output rd_addr_ready, rd_valid, rd_data, rd_resp
  );

endinterface

// ==== hw/fetch_pkg.sv ====
// Shared types, encodings and sizing constants for the instruction fetch stage; referenced by scoped names
package fetch_pkg;

  // Local instruction buffer depth
  localparam int L0_SLOTS   = 2;
  // Read requests allowed in flight on the core bus
  localparam int MAX_OT_TXN = 4;
  // Pointer width for the buffer slots
  localparam int L0_PTR_W   = (L0_SLOTS > 1) ? $clog2(L0_SLOTS) : 1;

  // Program counter, also used as the bus address
  typedef logic [31:0] pc_t;

  // Raw instruction word as returned by memory
  typedef logic [31:0] instr_raw_t;

  // Occupancy needs one extra bit to hold the full value
  typedef logic [$clog2(L0_SLOTS):0] occ_t;

  // Outstanding count, same reasoning as occupancy
  typedef logic [$clog2(MAX_OT_TXN):0] ot_cnt_t;

  // Buffer slot index
  typedef logic [L0_PTR_W-1:0] l0_ptr_t;

  // Core bus read response
  typedef enum logic {
    CB_OKAY  = 1'b0,
    CB_ERROR = 1'b1
  } cb_resp_e;

  // Core bus transfer size
  typedef enum logic [1:0] {
    CB_BYTE = 2'd0,
    CB_HALF = 2'd1,
    CB_WORD = 2'd2
  } cb_size_e;

  // Fetch control FSM
  //   IDLE        waits for the first start or redirect
  //   FETCH_CLEAR one cycle after a trigger, replies are dropped
  //   FETCH_RUN   normal streaming
  typedef enum logic [1:0] {
    IDLE        = 2'd0,
    FETCH_CLEAR = 2'd1,
    FETCH_RUN   = 2'd2
  } fetch_state_e;

  // Trap report towards the CSR logic
  typedef struct packed {
    logic active;
    pc_t  mtval;
  } trap_info_t;

endpackage
